/* verilog.f */
+incdir+tests
logic/fc_pkg.sv
logic/tree_level.sv
logic/weight_multiply.sv
logic/adder_tree.sv
logic/bias_output.sv
logic/fc_neuron_16.sv
tests/tb_fc_neuron_16.sv

/* Makefile */
# Verilator flow for the 16-input neuron
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP ?= tb_fc_neuron_16
RTL_TOP ?= fc_neuron_16
FLIST ?= verilog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?=
PASS_MSG ?= No errors

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := tests/fc_check.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

# RTL top only
lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

build: $(SIM_BIN)

# the log decides pass or fail
sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/fc_check.svh */
`ifndef FC_CHECK_SVH
`define FC_CHECK_SVH

// expected neuron output, straight from the fixed-point rule
// exact products, exact sum, bias at 22 fraction bits
// then round half up and clamp to Q7.8
function automatic fc_pkg::data_t neuron_reference(
	input fc_pkg::feature_vec_t features,
	input fc_pkg::coef_vec_t weights,
	input fc_pkg::data_t bias
);
	longint acc;
	longint scaled;
	// bias moved from 8 to 22 fraction bits
	acc = longint'(bias) <<< 14;
	for (int i = 0; i < fc_pkg::N_INPUTS; i++)
	begin
		// 64 bits hold any product and any sum of 16 of them
		acc = acc + longint'(features[i]) * longint'(weights[i]);
	end
	// half an output lsb, then drop 14 bits
	scaled = (acc + longint'(8192)) >>> 14;
	if (scaled > longint'(32767))
	begin
		neuron_reference = 16'sh7fff;
	end
	else if (scaled < longint'(-32768))
	begin
		neuron_reference = 16'sh8000;
	end
	else
	begin
		neuron_reference = fc_pkg::data_t'(scaled);
	end
endfunction

// one output value against its expectation
task automatic check_data(
	input string name,
	input fc_pkg::data_t expected,
	input fc_pkg::data_t actual
);
	checks++;
	if (actual !== expected)
	begin
		errors++;
		$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
	end
endtask

// cycles from strobe to result
task automatic check_latency(input string name, input int expected, input int actual);
	checks++;
	if (actual != expected)
	begin
		errors++;
		$display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
	end
endtask

`endif

/* tests/tb_fc_neuron_16.sv */
`timescale 1ns/100ps

module tb_fc_neuron_16;
	import fc_pkg::*;

	// strobe to valid_out, in clock edges
	localparam int LATENCY = 6;
	// longest wait for the pipeline to empty
	localparam int DRAIN_TIMEOUT = 100;

	// one pending result and the edge its vector was sampled on
	typedef struct packed {
		data_t value;
		int stamp;
	} expect_t;

	logic clk;
	logic rst;
	logic valid_in;
	feature_vec_t data_in;
	data_t data_out;
	logic valid_out;

	int seed = 56;
	int cycle;
	int errors;
	int checks;
	int test_num;
	int err_mark;
	expect_t exp_q[$];

	`include "fc_check.svh"

	fc_neuron_16 UUT (
		.clk(clk),
		.rst(rst),
		.valid_in(valid_in),
		.data_in(data_in),
		.data_out(data_out),
		.valid_out(valid_out)
	);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// rising edge count
	// read on falling edges only
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
	end

	// results compared where they are stable
	always @(negedge clk)
	begin
		expect_t head;
		if (valid_out === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("valid_out high at %0t with no vector pending", $time);
			end
			else
			begin
				head = exp_q.pop_front();
				check_data("data_out", head.value, data_out);
				// valid_out is taken on the rising edge after this one
				check_latency("latency", LATENCY, cycle + 1 - head.stamp);
			end
		end
	end

	// full range or scaled down so not every result clips
	task automatic make_random(output feature_vec_t vec);
		int r;
		for (int i = 0; i < N_INPUTS; i++)
		begin
			r = $random(seed);
			vec[i] = data_t'(r[15:0]) >>> r[18:16];
		end
	endtask

	// strobe one vector for the next rising edge
	task automatic send(input feature_vec_t vec, input data_t expected);
		expect_t entry;
		@(negedge clk);
		valid_in = 1'b1;
		data_in = vec;
		entry.value = expected;
		entry.stamp = cycle + 1;
		exp_q.push_back(entry);
	endtask

	// idle cycles carry junk data that must be ignored
	task automatic idle(input int n);
		feature_vec_t junk;
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			make_random(junk);
			valid_in = 1'b0;
			data_in = junk;
		end
	endtask

	// wait for every pending result, then report the test
	task automatic end_test(input string name);
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < DRAIN_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("timeout in %s, %0d results never appeared", name, exp_q.size());
			exp_q.delete();
		end
		test_num++;
		$display("test %0d %s done, %0d errors", test_num, name, errors - err_mark);
		err_mark = errors;
	endtask

	initial
	begin
		feature_vec_t vec;
		int r;
		rst = 1'b1;
		valid_in = 1'b0;
		data_in = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// nothing strobed so nothing may come out
		for (int i = 0; i < 20; i++)
		begin
			@(negedge clk);
			if (valid_out !== 1'b0)
			begin
				errors++;
				$display("valid_out not low at %0t after reset", $time);
			end
		end
		end_test("reset");

		// zero features leave only the bias
		send('0, DEFAULT_BIAS);
		idle(1);
		end_test("bias only");

		// one vector per cycle
		for (int i = 0; i < 200; i++)
		begin
			make_random(vec);
			send(vec, neuron_reference(vec, DEFAULT_WEIGHTS, DEFAULT_BIAS));
		end
		idle(1);
		end_test("back to back");

		// 0 to 3 idle cycles between strobes
		for (int i = 0; i < 100; i++)
		begin
			make_random(vec);
			send(vec, neuron_reference(vec, DEFAULT_WEIGHTS, DEFAULT_BIAS));
			r = $random(seed);
			idle(int'(r[1:0]));
		end
		idle(1);
		end_test("gapped");

		// every product at its largest with the sign of the weight
		for (int i = 0; i < N_INPUTS; i++)
		begin
			vec[i] = DEFAULT_WEIGHTS[i][15] ? 16'sh8000 : 16'sh7fff;
		end
		send(vec, 16'sh7fff);
		// every product at its most negative
		for (int i = 0; i < N_INPUTS; i++)
		begin
			vec[i] = DEFAULT_WEIGHTS[i][15] ? 16'sh7fff : 16'sh8000;
		end
		send(vec, 16'sh8000);
		// weight 0 is 1672
		// 4.0 times that plus bias 7 is 111.5
		vec = '0;
		vec[0] = 16'sd1024;
		send(vec, 16'sd112);
		// -4.0 gives -97.5 and the tie goes up to -97
		vec[0] = -16'sd1024;
		send(vec, -16'sd97);
		idle(1);
		end_test("saturation and rounding");

		// late strays still reach the compare process
		idle(10);
		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* logic/fc_neuron_16.sv */
`timescale 1ns/100ps

// one output neuron of a 16-input fully connected layer
// multiply 1 cycle, tree 4 cycles, bias 1 cycle
// valid_in at edge k gives valid_out at edge k+6
// a new vector may enter every cycle
module fc_neuron_16 #(
	parameter fc_pkg::coef_vec_t WEIGHTS = fc_pkg::DEFAULT_WEIGHTS,
	parameter fc_pkg::data_t BIAS = fc_pkg::DEFAULT_BIAS
) (
	input logic clk,
	input logic rst,
	input logic valid_in,
	input fc_pkg::feature_vec_t data_in,
	output fc_pkg::data_t data_out,
	output logic valid_out
);
	import fc_pkg::*;

	// multiply stage to tree
	product_bus_t products;
	// tree to bias stage
	sum_bus_t total;

	// weights are fixed at elaboration
	weight_multiply #(
		.WEIGHTS(WEIGHTS)
	) u_multiply (
		.clk(clk),
		.rst(rst),
		.valid_in(valid_in),
		.data_in(data_in),
		.products(products)
	);

	// pipelined pairwise sum
	adder_tree u_tree (
		.clk(clk),
		.rst(rst),
		.products(products),
		.total(total)
	);

	// bias added after the tree
	// same place as the last adder of the float version
	bias_output #(
		.BIAS(BIAS)
	) u_output (
		.clk(clk),
		.rst(rst),
		.total(total),
		.data_out(data_out),
		.valid_out(valid_out)
	);

endmodule

/* logic/bias_output.sv */
`timescale 1ns/100ps

// consumer stage
// bias add, round half up, saturate to Q7.8, register
module bias_output #(
	parameter fc_pkg::data_t BIAS = fc_pkg::DEFAULT_BIAS
) (
	input logic clk,
	input logic rst,
	input fc_pkg::sum_bus_t total,
	output fc_pkg::data_t data_out,
	output logic valid_out
);
	import fc_pkg::*;

	// fraction bits carried by the tree sum
	localparam int PROD_FRAC = FRAC_BITS_DATA + FRAC_BITS_COEF;
	// gap between sum and output scaling, 14
	localparam int ALIGN = PROD_FRAC - FRAC_BITS_DATA;
	// output limits held at sum width
	localparam acc_t OUT_MAX = 36'sd32767;
	localparam acc_t OUT_MIN = -36'sd32768;

	acc_t bias_aligned;
	acc_t biased;
	acc_t rounded;
	acc_t shifted;
	data_t result;

	// full sum is below 2^35 even with bias and rounding
	always_comb
	begin
		// bias moved up to 22 fraction bits
		bias_aligned = acc_t'(BIAS) <<< ALIGN;
		biased = total.sum + bias_aligned;
		// half an output lsb, ties go toward +inf
		rounded = biased + (acc_t'(1) <<< (ALIGN - 1));
		// arithmetic shift keeps the sign
		shifted = rounded >>> ALIGN;
		// clamp to the Q7.8 range
		if (shifted > OUT_MAX)
		begin
			result = data_t'(OUT_MAX);
		end
		else if (shifted < OUT_MIN)
		begin
			result = data_t'(OUT_MIN);
		end
		else
		begin
			result = data_t'(shifted);
		end
	end

	// output strobe, one cycle behind the tree
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_out <= 1'b0;
		end
		else
		begin
			valid_out <= total.valid;
		end
	end

	// result held until the next strobe
	always_ff @(posedge clk)
	begin
		if (total.valid)
		begin
			data_out <= result;
		end
	end

endmodule

/* logic/adder_tree.sv */
`timescale 1ns/100ps

// buffer stage
// four pipelined levels reduce 16 products to one sum
// up to four vectors in flight, one per level
module adder_tree (
	input logic clk,
	input logic rst,
	input fc_pkg::product_bus_t products,
	output fc_pkg::sum_bus_t total
);
	import fc_pkg::*;

	// valid entering each level, last one leaves the tree
	logic [TREE_LEVELS:0] level_valid;

	// partial sums between levels
	sum1_t [N_INPUTS/2-1:0] sum1;
	sum2_t [N_INPUTS/4-1:0] sum2;
	sum3_t [N_INPUTS/8-1:0] sum3;
	acc_t [N_INPUTS/16-1:0] sum4;

	assign level_valid[0] = products.valid;

	// 16 products to 8 sums
	tree_level #(
		.operand_t(prod_t),
		.sum_t(sum1_t),
		.N_OPERANDS(N_INPUTS)
	) u_level1 (
		.clk(clk),
		.rst(rst),
		.valid_in(level_valid[0]),
		.operands(products.prod),
		.valid_out(level_valid[1]),
		.sums(sum1)
	);

	// 8 to 4
	tree_level #(
		.operand_t(sum1_t),
		.sum_t(sum2_t),
		.N_OPERANDS(N_INPUTS/2)
	) u_level2 (
		.clk(clk),
		.rst(rst),
		.valid_in(level_valid[1]),
		.operands(sum1),
		.valid_out(level_valid[2]),
		.sums(sum2)
	);

	// 4 to 2
	tree_level #(
		.operand_t(sum2_t),
		.sum_t(sum3_t),
		.N_OPERANDS(N_INPUTS/4)
	) u_level3 (
		.clk(clk),
		.rst(rst),
		.valid_in(level_valid[2]),
		.operands(sum2),
		.valid_out(level_valid[3]),
		.sums(sum3)
	);

	// last pair, full sum still carries 22 fraction bits
	tree_level #(
		.operand_t(sum3_t),
		.sum_t(acc_t),
		.N_OPERANDS(N_INPUTS/8)
	) u_level4 (
		.clk(clk),
		.rst(rst),
		.valid_in(level_valid[3]),
		.operands(sum3),
		.valid_out(level_valid[4]),
		.sums(sum4)
	);

	assign total.valid = level_valid[TREE_LEVELS];
	assign total.sum = sum4[0];

endmodule

/* logic/weight_multiply.sv */
`timescale 1ns/100ps

// producer stage
// one fixed weight per feature, all 16 multiplies in parallel
module weight_multiply #(
	parameter fc_pkg::coef_vec_t WEIGHTS = fc_pkg::DEFAULT_WEIGHTS
) (
	input logic clk,
	input logic rst,
	input logic valid_in,
	input fc_pkg::feature_vec_t data_in,
	output fc_pkg::product_bus_t products
);
	import fc_pkg::*;

	// combinational products
	prod_t [N_INPUTS-1:0] prod_d;
	// registered products and their strobe
	prod_t [N_INPUTS-1:0] prod_q;
	logic valid_q;

	// Q7.8 x Q1.14 gives Q9.22, exact in 32 bits
	for (genvar i = 0; i < N_INPUTS; i++)
	begin : g_mul
		// sign extend both operands before the multiply
		assign prod_d[i] = prod_t'($signed(data_in[i])) * prod_t'($signed(WEIGHTS[i]));
	end

	// strobe follows the input by one cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= valid_in;
		end
	end

	// capture only on a strobe
	// idle cycles keep the old products
	always_ff @(posedge clk)
	begin
		if (valid_in)
		begin
			prod_q <= prod_d;
		end
	end

	// bundle for the adder tree
	assign products.valid = valid_q;
	assign products.prod = prod_q;

endmodule

/* logic/tree_level.sv */
`timescale 1ns/100ps

// one registered level of the adder tree
// adds neighbours 2i and 2i+1 into sum i
module tree_level #(
	parameter type operand_t = logic signed [15:0],
	parameter type sum_t = logic signed [16:0],
	parameter int N_OPERANDS = 2
) (
	input logic clk,
	input logic rst,
	input logic valid_in,
	input operand_t [N_OPERANDS-1:0] operands,
	output logic valid_out,
	output sum_t [N_OPERANDS/2-1:0] sums
);
	// half as many results as operands
	localparam int N_SUMS = N_OPERANDS / 2;

	sum_t [N_SUMS-1:0] pair_sum;

	// sum_t is wider than operand_t
	// so sign extend first, the add cannot overflow
	always_comb
	begin
		for (int i = 0; i < N_SUMS; i++)
		begin
			pair_sum[i] = sum_t'($signed(operands[2*i])) + sum_t'($signed(operands[2*i+1]));
		end
	end

	// valid moves one stage per clock
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_out <= 1'b0;
		end
		else
		begin
			valid_out <= valid_in;
		end
	end

	// sums only load with their strobe
	always_ff @(posedge clk)
	begin
		if (valid_in)
		begin
			sums <= pair_sum;
		end
	end

endmodule

/* logic/fc_pkg.sv */
package fc_pkg;

	// neuron geometry
	localparam int N_INPUTS = 16;
	// log2 of N_INPUTS, one pairwise level per bit
	localparam int TREE_LEVELS = 4;

	// fixed-point formats
	// features and output are Q7.8
	localparam int FRAC_BITS_DATA = 8;
	// weights are Q1.14
	localparam int FRAC_BITS_COEF = 14;

	// feature, output and bias value
	typedef logic signed [15:0] data_t;
	// weight
	typedef logic signed [15:0] coef_t;
	// exact feature x weight, 22 fraction bits
	typedef logic signed [31:0] prod_t;

	// each tree level grows one bit so no pair add can overflow
	typedef logic signed [32:0] sum1_t;
	typedef logic signed [33:0] sum2_t;
	typedef logic signed [34:0] sum3_t;
	// full 16-term sum
	typedef logic signed [35:0] acc_t;

	// element 0 is the lowest slice
	typedef data_t [N_INPUTS-1:0] feature_vec_t;
	typedef coef_t [N_INPUTS-1:0] coef_vec_t;

	// multiply stage to adder tree
	typedef struct packed {
		logic valid;
		prod_t [N_INPUTS-1:0] prod;
	} product_bus_t;

	// adder tree to bias stage
	typedef struct packed {
		logic valid;
		acc_t sum;
	} sum_bus_t;

	// trained weights rounded to Q1.14
	// listed from weight 15 down to weight 0
	localparam coef_vec_t DEFAULT_WEIGHTS = '{
		16'sd1024,
		16'sd5965,
		-16'sd4694,
		-16'sd8744,
		16'sd1165,
		-16'sd5718,
		16'sd2704,
		16'sd5514,
		-16'sd2894,
		16'sd3877,
		-16'sd4107,
		-16'sd8317,
		16'sd7672,
		16'sd2434,
		-16'sd8224,
		16'sd1672
	};

	// trained bias, about 0.027, rounded to Q7.8
	localparam data_t DEFAULT_BIAS = 16'sd7;

endpackage
